// File: dw_shift.f
dw_pkg.sv
dw_stream_if.sv
dw_member_select.sv
dw_shift_out.sv
dw_skid_slice.sv
dw_shift_top.sv
dw_shift_chk.sv
dw_shift_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compiles the dw_shift testbench with Verilator and runs it.
# Run from the project root.

verilator --binary --timing --assert -f dw_shift.f --top-module dw_shift_tb \
  -o dw_shift_sim || { echo "verilator build failed"; exit 1; }

out=$(./obj_dir/dw_shift_sim 2>&1)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "All tests passed" && exit 0 || exit 1

// File: dw_shift_tb.sv
`timescale 1ns/10ps

module dw_shift_tb
  import dw_pkg::*;
();

  localparam int MEMBERS     = 6;
  localparam int UNITS       = 2;
  localparam int CLK_NS      = 8;
  localparam int RAND_BEATS  = 400;
  localparam int WATCHDOG_NS = RAND_BEATS * 6 * 4 * CLK_NS;

  typedef word_t [UNITS-1:0] member_t;

  logic                           aclk;
  logic                           rst;
  logic                           s_valid;
  logic                           s_ready;
  word_t [MEMBERS-1:0][UNITS-1:0] s_data;
  sw_t                            s_sw_1;
  tag_t                           s_tag;
  logic                           s_last;
  logic                           m_valid;
  logic                           m_ready;
  member_t                        m_data;
  tag_t                           m_tag;
  logic                           m_last;

  member_t exp_data[$];
  tag_t    exp_tag[$];
  logic    exp_last[$];
  time     exp_time[$];           // acceptance time of the source beat.
  logic    rand_ready = 1'b0;     // random back-pressure on m_ready when set.
  logic    seen_input = 1'b0;

  dw_shift_top #(.MEMBERS(MEMBERS), .UNITS(UNITS)) DUT (
    .aclk(aclk), .rst(rst),
    .s_valid(s_valid), .s_ready(s_ready), .s_data(s_data),
    .s_sw_1(s_sw_1), .s_tag(s_tag), .s_last(s_last),
    .m_valid(m_valid), .m_ready(m_ready), .m_data(m_data),
    .m_tag(m_tag), .m_last(m_last)
  );

  always #(CLK_NS / 2) aclk = ~aclk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR time %0d ns %s got %0h expected %0h", $time, name, got, exp));
    end
  endtask

  // ------------------------------
  // reference model
  // ------------------------------

  always @(posedge aclk) begin
    int stride;
    if (!rst && s_valid && s_ready) begin
      seen_input = 1'b1;
      stride = int'(s_sw_1) + 1;
      for (int m = 0; m < MEMBERS; m++) begin
        if (m % stride == stride - 1) begin
          exp_data.push_back(s_data[m]);
          exp_tag.push_back(s_tag);
          exp_last.push_back(s_last && (m + stride >= MEMBERS));  // no later member kept.
          exp_time.push_back($time);
        end
      end
    end
  end

  always @(posedge aclk) begin
    time t_acc;
    if (!rst && !seen_input) begin
      check("m_valid", 64'(m_valid), 64'(0));
    end
    if (!rst && m_valid && m_ready) begin
      if (exp_data.size() == 0) begin
        abort_run("an output beat arrived with no expected entry left in the model");
      end else begin
        t_acc = exp_time.pop_front();
        check("m_data", 64'(m_data), 64'(exp_data.pop_front()));
        check("m_tag", 64'(m_tag), 64'(exp_tag.pop_front()));
        check("m_last", 64'(m_last), 64'(exp_last.pop_front()));
        check("m_valid latency ok", 64'(($time - t_acc) >= time'(3 * CLK_NS)), 64'(1));
      end
    end
  end

  always @(posedge aclk) begin
    if (rand_ready) begin
      m_ready <= ($urandom_range(3, 0) != 0);
    end else begin
      m_ready <= 1'b1;
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------

  // patterned words carry tag, member and unit so ordering errors show up in m_data.
  task automatic send_beat(input sw_t sw_1, input logic last, input int gap, input logic rnd);
    word_t [MEMBERS-1:0][UNITS-1:0] beat;
    tag_t                           tag;
    tag = tag_t'($urandom);
    for (int m = 0; m < MEMBERS; m++) begin
      for (int u = 0; u < UNITS; u++) begin
        beat[m][u] = rnd ? word_t'($urandom) : word_t'({tag, 4'(m), 4'(u)});
      end
    end
    if (gap > 0) begin
      s_valid <= 1'b0;
      repeat (gap) @(posedge aclk);
    end
    s_valid <= 1'b1;
    s_data  <= beat;
    s_sw_1  <= sw_1;
    s_tag   <= tag;
    s_last  <= last;
    @(posedge aclk);
    while (!s_ready) @(posedge aclk);
  endtask

  task automatic wait_drain();
    s_valid <= 1'b0;
    repeat (2) @(posedge aclk);
    for (int i = 0; i < 2000 && exp_data.size() != 0; i++) @(posedge aclk);
    repeat (8) @(posedge aclk);  // lets any duplicate beat show up.
  endtask

  initial begin
    void'($urandom(32'h9454c20b));
    aclk    = 1'b0;
    rst     = 1'b1;
    s_valid = 1'b0;
    s_data  = '0;
    s_sw_1  = '0;
    s_tag   = '0;
    s_last  = 1'b0;
    m_ready = 1'b1;
    repeat (2) @(posedge aclk);
    rst <= 1'b0;
    repeat (6) @(posedge aclk);  // m_valid must stay low with no input.

    for (int sw = 0; sw < 3; sw++) begin
      send_beat(sw_t'(sw), 1'b0, 0, 1'b0);
      send_beat(sw_t'(sw), 1'b1, 0, 1'b0);
    end
    wait_drain();

    for (int b = 0; b < 20; b++) begin
      send_beat(sw_t'($urandom_range(2, 0)), ($urandom_range(3, 0) == 0), 0, 1'b1);
    end
    wait_drain();

    rand_ready <= 1'b1;
    for (int b = 0; b < RAND_BEATS; b++) begin
      send_beat(sw_t'($urandom_range(2, 0)), ($urandom_range(3, 0) == 0),
                ($urandom_range(3, 0) == 0) ? int'($urandom_range(3, 1)) : 0, 1'b1);
    end
    rand_ready <= 1'b0;
    wait_drain();

    if (exp_data.size() != 0) begin
      abort_run($sformatf("%0d expected output beats never arrived", exp_data.size()));
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired before the tests finished");
  end

endmodule

// File: dw_shift_chk.sv
`timescale 1ns/10ps

module dw_shift_chk
  import dw_pkg::*;
#(
  parameter int UNITS = 2
) (
  input logic              aclk,
  input logic              rst,
  input logic              s_valid,
  input sw_t               s_sw_1,
  input logic              m_valid,
  input logic              m_ready,
  input word_t [UNITS-1:0] m_data,
  input tag_t              m_tag,
  input logic              m_last
);

  // ------------------------------
  // handshake properties
  // ------------------------------

  a_sw_legal: assert property (@(posedge aclk) disable iff (rst)
    s_valid |-> (s_sw_1 != 2'd3))
    else $error("reserved stride code seen on s_sw_1");

  a_stall_hold: assert property (@(posedge aclk) disable iff (rst)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_data) && $stable(m_tag) && $stable(m_last)))
    else $error("output beat changed while stalled");

  a_reset_idle: assert property (@(posedge aclk) rst |=> !m_valid)
    else $error("m_valid high right after reset");

endmodule

bind dw_shift_top dw_shift_chk #(.UNITS(UNITS)) u_chk (
  .aclk(aclk), .rst(rst), .s_valid(s_valid), .s_sw_1(s_sw_1),
  .m_valid(m_valid), .m_ready(m_ready), .m_data(m_data), .m_tag(m_tag), .m_last(m_last)
);

// File: dw_shift_top.sv
`timescale 1ns/10ps

module dw_shift_top
  import dw_pkg::*;
#(
  parameter int MEMBERS = 6,
  parameter int UNITS   = 2
) (
  input  logic                           aclk,
  input  logic                           rst,
  input  logic                           s_valid,
  output logic                           s_ready,
  input  word_t [MEMBERS-1:0][UNITS-1:0] s_data,
  input  sw_t                            s_sw_1,
  input  tag_t                           s_tag,
  input  logic                           s_last,
  output logic                           m_valid,
  input  logic                           m_ready,
  output word_t [UNITS-1:0]              m_data,
  output tag_t                           m_tag,
  output logic                           m_last
);

  // ------------------------------
  // internal streams
  // ------------------------------

  dw_stream_if #(.LANES(MEMBERS), .UNITS(UNITS)) sel_bus ();  // compacted beats.
  dw_stream_if #(.LANES(1),       .UNITS(UNITS)) out_bus ();  // one member per beat.

  dw_member_select #(
    .MEMBERS (MEMBERS),
    .UNITS   (UNITS)
  ) u_select (
    .aclk    (aclk),
    .rst     (rst),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .s_sw_1  (s_sw_1),
    .s_tag   (s_tag),
    .s_last  (s_last),
    .sel     (sel_bus)
  );

  dw_shift_out #(
    .MEMBERS (MEMBERS),
    .UNITS   (UNITS)
  ) u_shift (
    .aclk    (aclk),
    .rst     (rst),
    .sel     (sel_bus),
    .ser     (out_bus)
  );

  dw_skid_slice #(
    .UNITS   (UNITS)
  ) u_slice (
    .aclk    (aclk),
    .rst     (rst),
    .in_bus  (out_bus),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data),
    .m_tag   (m_tag),
    .m_last  (m_last)
  );

endmodule

// File: dw_skid_slice.sv
`timescale 1ns/10ps

module dw_skid_slice
  import dw_pkg::*;
#(
  parameter int UNITS = 2
) (
  input  logic              aclk,
  input  logic              rst,
  dw_stream_if.snk          in_bus,
  output logic              m_valid,
  input  logic              m_ready,
  output word_t [UNITS-1:0] m_data,
  output tag_t              m_tag,
  output logic              m_last
);

  logic              ready_q;
  logic              ready_early;
  logic              skid_valid;
  word_t [UNITS-1:0] skid_data;
  tag_t              skid_tag;
  logic              skid_last;
  logic              main_valid_nxt;
  logic              skid_valid_nxt;
  logic              in_to_main;
  logic              in_to_skid;
  logic              skid_to_main;

  assign in_bus.ready = ready_q;  // registered so the stall reaches upstream a cycle late.

  // stay ready unless the skid entry is full or about to be.
  assign ready_early = m_ready || (!skid_valid && (!m_valid || !in_bus.valid));

  always_comb begin
    main_valid_nxt = m_valid;
    skid_valid_nxt = skid_valid;
    in_to_main     = 1'b0;
    in_to_skid     = 1'b0;
    skid_to_main   = 1'b0;
    if (ready_q) begin
      if (m_ready || !m_valid) begin
        main_valid_nxt = in_bus.valid;
        in_to_main     = 1'b1;
      end else begin
        skid_valid_nxt = in_bus.valid;  // the beat in flight goes to the skid entry.
        in_to_skid     = 1'b1;
      end
    end else if (m_ready) begin
      main_valid_nxt = skid_valid;
      skid_valid_nxt = 1'b0;
      skid_to_main   = 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
      ready_q    <= 1'b0;
    end else begin
      m_valid    <= main_valid_nxt;
      skid_valid <= skid_valid_nxt;
      ready_q    <= ready_early;
    end
  end

  always_ff @(posedge aclk) begin
    if (in_to_main) begin
      m_data <= in_bus.data[0];
      m_tag  <= in_bus.tag;
      m_last <= in_bus.last;
    end else if (skid_to_main) begin
      m_data <= skid_data;
      m_tag  <= skid_tag;
      m_last <= skid_last;
    end
    if (in_to_skid) begin
      skid_data <= in_bus.data[0];
      skid_tag  <= in_bus.tag;
      skid_last <= in_bus.last;
    end
  end

endmodule

// File: dw_shift_out.sv
`timescale 1ns/10ps

module dw_shift_out
  import dw_pkg::*;
#(
  parameter int MEMBERS = 6,
  parameter int UNITS   = 2
) (
  input  logic     aclk,
  input  logic     rst,
  dw_stream_if.snk sel,
  dw_stream_if.src ser
);

  shift_state_e                   state;
  cnt_t                           remain;   // members still to be sent.
  word_t [MEMBERS-1:0][UNITS-1:0] sh_data;
  tag_t                           cur_tag;
  logic                           cur_last;
  logic                           load;
  logic                           ser_fire;
  logic                           at_final;

  assign ser_fire = ser.valid && ser.ready;
  assign at_final = (remain == cnt_t'(1));
  assign load     = sel.valid && sel.ready;

  // a new beat may load while the final member of the previous one leaves.
  assign sel.ready = (state == SH_IDLE) || (ser_fire && at_final);

  // ------------------------------
  // control
  // ------------------------------

  always_ff @(posedge aclk) begin
    if (rst) begin
      state  <= SH_IDLE;
      remain <= '0;
    end else if (load) begin
      state  <= (sel.count != '0) ? SH_BUSY : SH_IDLE;
      remain <= sel.count;
    end else if (ser_fire) begin
      remain <= remain - 1'b1;
      if (at_final) begin
        state <= SH_IDLE;
      end
    end
  end

  // ------------------------------
  // shift register
  // ------------------------------

  always_ff @(posedge aclk) begin
    if (load) begin
      sh_data  <= sel.data;
      cur_tag  <= sel.tag;
      cur_last <= sel.last;
    end else if (ser_fire) begin
      for (int l = 0; l < MEMBERS - 1; l++) begin
        sh_data[l] <= sh_data[l+1];  // next member moves into lane 0.
      end
    end
  end

  assign ser.valid   = (state == SH_BUSY);
  assign ser.data[0] = sh_data[0];
  assign ser.tag     = cur_tag;
  assign ser.last    = cur_last && at_final;
  assign ser.count   = cnt_t'(1);  // one member per beat on this stream.

endmodule

// File: dw_member_select.sv
`timescale 1ns/10ps

module dw_member_select
  import dw_pkg::*;
#(
  parameter int MEMBERS = 6,
  parameter int UNITS   = 2
) (
  input  logic                           aclk,
  input  logic                           rst,
  input  logic                           s_valid,
  output logic                           s_ready,
  input  word_t [MEMBERS-1:0][UNITS-1:0] s_data,
  input  sw_t                            s_sw_1,
  input  tag_t                           s_tag,
  input  logic                           s_last,
  dw_stream_if.src                       sel
);

  word_t [MEMBERS-1:0][UNITS-1:0] pick;
  cnt_t                           pick_cnt;
  logic                           s_fire;

  // ------------------------------
  // stride selection
  // ------------------------------

  // lane k takes member k*stride + stride-1, so the kept members land in the low lanes.
  always_comb begin
    int src;
    pick = '0;
    for (int k = 0; k < MEMBERS; k++) begin
      src = k * (int'(s_sw_1) + 1) + int'(s_sw_1);
      if (src < MEMBERS) begin
        pick[k] = s_data[src];
      end
    end
  end

  always_comb begin
    case (s_sw_1)
      2'd0:    pick_cnt = cnt_t'(MEMBERS);
      2'd1:    pick_cnt = cnt_t'(MEMBERS / 2);
      default: pick_cnt = cnt_t'(MEMBERS / 3);  // the reserved code falls here too.
    endcase
  end

  // ------------------------------
  // output register
  // ------------------------------

  assign s_ready = !sel.valid || sel.ready;  // empty or draining this cycle.
  assign s_fire  = s_valid && s_ready;

  always_ff @(posedge aclk) begin
    if (rst) begin
      sel.valid <= 1'b0;
    end else if (s_ready) begin
      sel.valid <= s_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (s_fire) begin
      sel.data  <= pick;
      sel.count <= pick_cnt;
      sel.tag   <= s_tag;
      sel.last  <= s_last;
    end
  end

endmodule

// File: dw_stream_if.sv
`timescale 1ns/10ps

interface dw_stream_if
  import dw_pkg::*;
#(
  parameter int LANES = 1,
  parameter int UNITS = 2
) ();

  logic                         valid;
  logic                         ready;
  logic                         last;
  word_t [LANES-1:0][UNITS-1:0] data;
  cnt_t                         count;  // number of members held in the low lanes of data.
  tag_t                         tag;

  modport src (
    output valid,
    output last,
    output data,
    output count,
    output tag,
    input  ready
  );

  modport snk (
    input  valid,
    input  last,
    input  data,
    input  count,
    input  tag,
    output ready
  );

endinterface

// File: dw_pkg.sv
package dw_pkg;

  // ------------------------------
  // word and field widths
  // ------------------------------

  localparam int WORD_WIDTH = 16;  // accumulator word width.

  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [7:0]            tag_t;   // user tag that rides along with a beat.
  typedef logic [1:0]            sw_t;    // stride minus one. The code 3 is reserved.
  typedef logic [3:0]            cnt_t;   // number of selected members in a beat.

  // ------------------------------
  // shifter state
  // ------------------------------

  typedef enum logic {
    SH_IDLE,  // waiting for a compacted beat.
    SH_BUSY   // sending members out one per beat.
  } shift_state_e;

endpackage
